//--- hw/aluExecute.sv
`timescale 1ns/100ps
module aluExecute (
   input  wiscPkg::ctrl_s              ctrl,
   input  logic [wiscPkg::dataW-1:0]   rdDataA,
   input  logic [wiscPkg::dataW-1:0]   rdDataB,
   input  logic [wiscPkg::dataW-1:0]   imm5Ext,
   output logic [wiscPkg::dataW-1:0]   aluOut,
   output logic                        condTrue
);
   import wiscPkg::*;

   logic [dataW-1:0] bOp;
   logic [dataW-1:0] aEff;
   logic [dataW-1:0] bEff;
   logic [dataW-1:0] sum;
   logic carry;
   logic ovf;
   logic zeroF;
   logic signF;
   logic [3:0] shAmt;
   logic [2*dataW-1:0] rotL;
   logic [2*dataW-1:0] rotR;

   always_comb begin
      case (ctrl.bSrc)
         bSrcImm: bOp = imm5Ext;
         bSrcZero: bOp = '0;               // branches test rs alone
         default: bOp = rdDataB;
      endcase
   end

   assign aEff = ctrl.invA ? ~rdDataA : rdDataA;
   assign bEff = ctrl.invB ? ~bOp : bOp;
   assign {carry, sum} = {1'b0, aEff} + {1'b0, bEff} + {{dataW{1'b0}}, ctrl.cin};
   assign ovf = (aEff[dataW-1] == bEff[dataW-1]) && (sum[dataW-1] != aEff[dataW-1]);

   assign shAmt = bOp[3:0];              // only low 4 bits count
   assign rotL = {rdDataA, rdDataA} << shAmt;
   assign rotR = {rdDataA, rdDataA} >> shAmt;

   always_comb begin
      case (ctrl.aluOp)
         aluXor: aluOut = aEff ^ bEff;
         aluAndn: aluOut = aEff & bEff;
         aluRol: aluOut = rotL[2*dataW-1:dataW];
         aluSll: aluOut = rdDataA << shAmt;
         aluRor: aluOut = rotR[dataW-1:0];
         aluSrl: aluOut = rdDataA >> shAmt;
         default: aluOut = sum;            // add, sub, address calc
      endcase
   end

   assign zeroF = (sum == '0);
   assign signF = sum[dataW-1] ^ ovf;    // true signed less-than on a compare

   always_comb begin
      case (ctrl.condSel)
         cndZero: condTrue = zeroF;
         cndNotZero: condTrue = ~zeroF;
         cndSign: condTrue = signF;
         cndNotSign: condTrue = ~signF;
         cndSignOrZero: condTrue = signF | zeroF;
         cndCarry: condTrue = carry;
         cndAlways: condTrue = 1'b1;
         default: condTrue = 1'b0;
      endcase
   end

endmodule

//--- hw/busSequencer.sv
`timescale 1ns/100ps
module busSequencer (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic                           cyc,
   input  logic                           stb,
   input  logic                           we,
   input  logic [3:0]                     adr,
   input  logic [wiscPkg::dataW-1:0]      datWr,
   output logic                           ack,
   output logic [wiscPkg::dataW-1:0]      datRd,
   output logic                           memCyc,
   output logic                           memStb,
   output logic                           memWe,
   output logic [wiscPkg::dataW-1:0]      memAdr,
   output logic [wiscPkg::dataW-1:0]      memDatWr,
   input  logic                           memAck,
   input  wiscPkg::ctrl_s                 ctrl,
   input  logic [wiscPkg::dataW-1:0]      aluOut,
   input  logic [wiscPkg::dataW-1:0]      storeData,
   input  logic [wiscPkg::dataW-1:0]      nextPc,
   input  logic [wiscPkg::dataW-1:0]      hostRdData,
   output wiscPkg::instrWord_u            instr,
   output logic [wiscPkg::dataW-1:0]      pc,
   output logic                           commit,
   output logic [wiscPkg::regAddrW-1:0]   hostRegAddr
);
   import wiscPkg::*;

   logic [1:0] state;
   logic isWrite;          // current host access is an instruction
   logic halted;
   logic error;
   logic needMem;
   logic finalStep;

   assign needMem = (ctrl.memRd | ctrl.memWrt) & ~halted;
   assign finalStep = (state == stDone) || (state == stMem && memAck);
   assign ack = finalStep;               // never ahead of memAck on loads/stores
   assign commit = finalStep & isWrite & ~halted & ~ctrl.halt & ~ctrl.illegal;
   assign memAdr = aluOut;               // rs + imm5
   assign memDatWr = storeData;
   assign hostRegAddr = regAddrW'(adr - hostRegBase);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= stIdle;
         isWrite <= 1'b0;
         halted <= 1'b0;
         error <= 1'b0;
         pc <= '0;
         memCyc <= 1'b0;
         memStb <= 1'b0;
         memWe <= 1'b0;
      end else begin
         case (state)
            stIdle: if (cyc && stb) begin
               isWrite <= we;
               state <= we ? stExec : stDone;    // reads ack next cycle
            end
            stExec: if (needMem) begin
               memCyc <= 1'b1;                   // cyc and stb rise together
               memStb <= 1'b1;
               memWe <= ctrl.memWrt;
               state <= stMem;
            end else begin
               state <= stDone;
            end
            stMem: if (memAck) begin
               memCyc <= 1'b0;
               memStb <= 1'b0;
               memWe <= 1'b0;
               state <= stIdle;
            end
            default: state <= stIdle;
         endcase
         if (finalStep && isWrite && !halted) begin
            halted <= ctrl.halt;
            error <= error | ctrl.illegal;      // sticky
         end
         if (commit) pc <= nextPc;
      end
   end

   always_ff @(posedge clk) begin
      if (state == stIdle && cyc && stb) begin
         if (we) begin
            instr <= datWr;
         end else begin
            case (adr)
               hostPcAddr: datRd <= pc;
               hostStatusAddr: datRd <= {{(dataW-2){1'b0}}, error, halted};
               default: datRd <= (adr < hostPcAddr) ? hostRdData : '0;
            endcase
         end
      end
   end

endmodule

//--- hw/instrDecode.sv
`timescale 1ns/100ps
module instrDecode (
   input  wiscPkg::instrWord_u         instr,
   output wiscPkg::ctrl_s              ctrl,
   output logic [wiscPkg::dataW-1:0]   imm5Ext,
   output logic [wiscPkg::dataW-1:0]   imm8Ext,
   output logic [wiscPkg::dataW-1:0]   imm11Ext
);
   import wiscPkg::*;

   logic [4:0] op;
   logic [1:0] func;

   // ADD/SUB/XOR/ANDN style encoding of the low two bits
   function automatic logic [2:0] arithOp(input logic [1:0] f);
      return f[1] ? (f[0] ? aluAndn : aluXor) : aluAdd;
   endfunction

   assign op = instr.rForm.opcode;
   assign func = instr.rForm.func;

   assign imm5Ext = ctrl.zeroExt ? {{(dataW-5){1'b0}}, instr.iForm.imm5}
                                 : {{(dataW-5){instr.iForm.imm5[4]}}, instr.iForm.imm5};
   assign imm8Ext = ctrl.zeroExt ? {{(dataW-8){1'b0}}, instr.biForm.imm8}
                                 : {{(dataW-8){instr.biForm.imm8[7]}}, instr.biForm.imm8};
   assign imm11Ext = {{(dataW-11){instr.jForm.imm11[10]}}, instr.jForm.imm11};

   always_comb begin
      ctrl = '0;                       // everything off, then per opcode
      ctrl.aluOp = aluAdd;
      ctrl.bSrc = bSrcReg;
      ctrl.condSel = cndNone;
      ctrl.wbSel = wbAlu;
      ctrl.jumpSel = jmpNone;
      case (op)
         opHalt: ctrl.halt = 1'b1;
         opNop: ;
         opAddi, opSubi, opXori, opAndni: begin
            ctrl.regWrt = 1'b1;
            ctrl.destSel = dstRdI;
            ctrl.bSrc = bSrcImm;
            ctrl.aluOp = arithOp(op[1:0]);
            ctrl.zeroExt = op[1];             // XORI, ANDNI take zero ext imm
            ctrl.invA = (op == opSubi);       // imm - rs
            ctrl.cin = (op == opSubi);
            ctrl.invB = (op == opAndni);
         end
         opRoli, opSlli, opRori, opSrli: begin
            ctrl.regWrt = 1'b1;
            ctrl.destSel = dstRdI;
            ctrl.bSrc = bSrcImm;
            ctrl.zeroExt = 1'b1;
            ctrl.aluOp = {1'b1, op[1:0]};
         end
         opAluArith: begin
            ctrl.regWrt = 1'b1;
            ctrl.destSel = dstRdR;
            ctrl.aluOp = arithOp(func);
            ctrl.invA = (func == 2'b01);      // SUB is rt - rs
            ctrl.cin = (func == 2'b01);
            ctrl.invB = (func == 2'b11);
         end
         opAluShift: begin
            ctrl.regWrt = 1'b1;
            ctrl.destSel = dstRdR;
            ctrl.aluOp = {1'b1, func};
         end
         opSeq, opSlt, opSle, opSco: begin
            ctrl.regWrt = 1'b1;
            ctrl.setOp = 1'b1;
            ctrl.destSel = dstRdR;
            ctrl.invB = (op != opSco);        // rs - rt for the compares
            ctrl.cin = (op != opSco);
            case (op[1:0])
               2'b00: ctrl.condSel = cndZero;
               2'b01: ctrl.condSel = cndSign;
               2'b10: ctrl.condSel = cndSignOrZero;
               default: ctrl.condSel = cndCarry;
            endcase
         end
         opLd: begin
            ctrl.regWrt = 1'b1;
            ctrl.memRd = 1'b1;
            ctrl.destSel = dstRdI;
            ctrl.bSrc = bSrcImm;
            ctrl.wbSel = wbMem;
         end
         opSt, opStu: begin
            ctrl.memWrt = 1'b1;
            ctrl.bSrc = bSrcImm;
            ctrl.regWrt = op[1];              // STU writes the address back to rs
            ctrl.destSel = dstRs;
         end
         opLbi, opSlbi: begin
            ctrl.regWrt = 1'b1;
            ctrl.destSel = dstRs;
            ctrl.zeroExt = (op == opSlbi);
            ctrl.wbSel = (op == opSlbi) ? wbSlbi : wbImm8;
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            ctrl.bSrc = bSrcZero;             // flags of rs + 0
            ctrl.jumpSel = jmpBranch;
            case (op[1:0])
               2'b00: ctrl.condSel = cndZero;
               2'b01: ctrl.condSel = cndNotZero;
               2'b10: ctrl.condSel = cndSign;
               default: ctrl.condSel = cndNotSign;
            endcase
         end
         opJ, opJr, opJal, opJalr: begin
            ctrl.condSel = cndAlways;
            ctrl.jumpSel = op[0] ? jmpReg : jmpDisp;
            ctrl.regWrt = op[1];
            ctrl.linkWrt = op[1];
            ctrl.wbSel = wbLinkPc;
         end
         default: ctrl.illegal = 1'b1;      // includes siic and RTI
      endcase
   end

endmodule

//--- hw/regFile.sv
`timescale 1ns/100ps
module regFile (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic [wiscPkg::regAddrW-1:0]   rdAddrA,
   input  logic [wiscPkg::regAddrW-1:0]   rdAddrB,
   input  logic [wiscPkg::regAddrW-1:0]   hostAddr,
   input  wiscPkg::wbReq_s                wbReq,
   output logic [wiscPkg::dataW-1:0]      rdDataA,
   output logic [wiscPkg::dataW-1:0]      rdDataB,
   output logic [wiscPkg::dataW-1:0]      hostData
);
   import wiscPkg::*;

   logic [dataW-1:0] regs [regCnt];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         regs <= '{default: '0};
      end else if (wbReq.wrEn) begin        // wrEn already qualified by commit
         regs[wbReq.dest] <= wbReq.data;
      end
   end

   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB];       // also the store data
   assign hostData = regs[hostAddr];     // host side read port

endmodule

//--- hw/resultStage.sv
`timescale 1ns/100ps
module resultStage (
   input  wiscPkg::ctrl_s              ctrl,
   input  wiscPkg::instrWord_u         instr,
   input  logic [wiscPkg::dataW-1:0]   pc,
   input  logic [wiscPkg::dataW-1:0]   aluOut,
   input  logic [wiscPkg::dataW-1:0]   memDatRd,
   input  logic                        condTrue,
   input  logic [wiscPkg::dataW-1:0]   imm8Ext,
   input  logic [wiscPkg::dataW-1:0]   imm11Ext,
   input  logic [wiscPkg::dataW-1:0]   rdDataA,
   input  logic                        commit,
   output wiscPkg::wbReq_s             wbReq,
   output logic [wiscPkg::dataW-1:0]   nextPc
);
   import wiscPkg::*;

   logic [dataW-1:0] pcPlus2;
   logic [dataW-1:0] target;

   assign pcPlus2 = pc + dataW'(2);

   always_comb begin
      if (ctrl.linkWrt) begin
         wbReq.dest = regAddrW'(linkReg);
      end else begin
         case (ctrl.destSel)
            dstRdR: wbReq.dest = instr.rForm.rd;
            dstRdI: wbReq.dest = instr.iForm.rd;
            default: wbReq.dest = instr.iForm.rs;   // LBI, SLBI, STU
         endcase
      end
   end

   always_comb begin
      case (ctrl.wbSel)
         wbMem: wbReq.data = memDatRd;            // straight off the bus at memAck
         wbLinkPc: wbReq.data = pcPlus2;
         wbImm8: wbReq.data = imm8Ext;
         wbSlbi: wbReq.data = {rdDataA[dataW-9:0], imm8Ext[7:0]};
         default: wbReq.data = ctrl.setOp ? {{(dataW-1){1'b0}}, condTrue} : aluOut;
      endcase
   end

   assign wbReq.wrEn = ctrl.regWrt & commit;

   always_comb begin
      case (ctrl.jumpSel)
         jmpDisp: target = pcPlus2 + imm11Ext;
         jmpReg: target = rdDataA + imm8Ext;      // JR, JALR
         default: target = pcPlus2 + imm8Ext;     // conditional branches
      endcase
   end

   assign nextPc = (ctrl.jumpSel != jmpNone && condTrue) ? target : pcPlus2;

endmodule

//--- hw/wiscCore.sv
`timescale 1ns/100ps
module wiscCore (
   input  logic                        clk,
   input  logic                        rstN,
   input  logic                        cyc,
   input  logic                        stb,
   input  logic                        we,
   input  logic [3:0]                  adr,
   input  logic [wiscPkg::dataW-1:0]   datWr,
   output logic [wiscPkg::dataW-1:0]   datRd,
   output logic                        ack,
   output logic                        memCyc,
   output logic                        memStb,
   output logic                        memWe,
   output logic [wiscPkg::dataW-1:0]   memAdr,
   output logic [wiscPkg::dataW-1:0]   memDatWr,
   input  logic [wiscPkg::dataW-1:0]   memDatRd,
   input  logic                        memAck
);
   import wiscPkg::*;

   instrWord_u instr;
   ctrl_s ctrl;
   wbReq_s wbReq;
   logic [dataW-1:0] imm5Ext;
   logic [dataW-1:0] imm8Ext;
   logic [dataW-1:0] imm11Ext;
   logic [dataW-1:0] rdDataA;
   logic [dataW-1:0] rdDataB;
   logic [dataW-1:0] hostRdData;
   logic [dataW-1:0] aluOut;
   logic [dataW-1:0] nextPc;
   logic [dataW-1:0] pc;
   logic [regAddrW-1:0] hostRegAddr;
   logic condTrue;
   logic commit;

   busSequencer i_busSequencer (
      .clk, .rstN, .cyc, .stb, .we, .adr, .datWr, .ack, .datRd,
      .memCyc, .memStb, .memWe, .memAdr, .memDatWr, .memAck,
      .ctrl, .aluOut, .storeData(rdDataB), .nextPc, .hostRdData,
      .instr, .pc, .commit, .hostRegAddr
   );

   instrDecode i_instrDecode (.instr, .ctrl, .imm5Ext, .imm8Ext, .imm11Ext);

   regFile i_regFile (
      .clk, .rstN,
      .rdAddrA(instr.iForm.rs),      // rs, bits 10:8
      .rdAddrB(instr.rForm.rt),      // rt of R-form, store data of ST/STU
      .hostAddr(hostRegAddr),
      .wbReq, .rdDataA, .rdDataB,
      .hostData(hostRdData)
   );

   aluExecute i_aluExecute (.ctrl, .rdDataA, .rdDataB, .imm5Ext, .aluOut, .condTrue);

   resultStage i_resultStage (
      .ctrl, .instr, .pc, .aluOut, .memDatRd, .condTrue,
      .imm8Ext, .imm11Ext, .rdDataA, .commit, .wbReq, .nextPc
   );

endmodule

//--- hw/wiscPkg.sv
package wiscPkg;

   localparam int dataW = 16;       // data and instruction width
   localparam int regCnt = 8;
   localparam int regAddrW = 3;
   localparam int linkReg = 7;      // return address lands here

   // top five bits of the instruction word
   localparam logic [4:0] opHalt = 5'b00000;
   localparam logic [4:0] opNop = 5'b00001;
   localparam logic [4:0] opJ = 5'b00100;
   localparam logic [4:0] opJr = 5'b00101;
   localparam logic [4:0] opJal = 5'b00110;
   localparam logic [4:0] opJalr = 5'b00111;
   localparam logic [4:0] opAddi = 5'b01000;
   localparam logic [4:0] opSubi = 5'b01001;
   localparam logic [4:0] opXori = 5'b01010;
   localparam logic [4:0] opAndni = 5'b01011;
   localparam logic [4:0] opBeqz = 5'b01100;
   localparam logic [4:0] opBnez = 5'b01101;
   localparam logic [4:0] opBltz = 5'b01110;
   localparam logic [4:0] opBgez = 5'b01111;
   localparam logic [4:0] opSt = 5'b10000;
   localparam logic [4:0] opLd = 5'b10001;
   localparam logic [4:0] opSlbi = 5'b10010;
   localparam logic [4:0] opStu = 5'b10011;
   localparam logic [4:0] opRoli = 5'b10100;
   localparam logic [4:0] opSlli = 5'b10101;
   localparam logic [4:0] opRori = 5'b10110;
   localparam logic [4:0] opSrli = 5'b10111;
   localparam logic [4:0] opLbi = 5'b11000;
   localparam logic [4:0] opAluShift = 5'b11010;   // ROL SLL ROR SRL by function field
   localparam logic [4:0] opAluArith = 5'b11011;   // ADD SUB XOR ANDN by function field
   localparam logic [4:0] opSeq = 5'b11100;
   localparam logic [4:0] opSlt = 5'b11101;
   localparam logic [4:0] opSle = 5'b11110;
   localparam logic [4:0] opSco = 5'b11111;

   localparam logic [3:0] hostRegBase = 4'd0;      // 0..7 read r0..r7
   localparam logic [3:0] hostPcAddr = 4'd8;
   localparam logic [3:0] hostStatusAddr = 4'd9;   // bit0 halted, bit1 error

   localparam logic [2:0] aluAdd = 3'b000;
   localparam logic [2:0] aluXor = 3'b010;
   localparam logic [2:0] aluAndn = 3'b011;        // b arrives already inverted
   localparam logic [2:0] aluRol = 3'b100;         // shifts share the low two opcode bits
   localparam logic [2:0] aluSll = 3'b101;
   localparam logic [2:0] aluRor = 3'b110;
   localparam logic [2:0] aluSrl = 3'b111;

   localparam logic [1:0] bSrcReg = 2'd0;
   localparam logic [1:0] bSrcImm = 2'd1;
   localparam logic [1:0] bSrcZero = 2'd2;

   localparam logic [1:0] dstRdR = 2'd0;           // bits 4:2
   localparam logic [1:0] dstRdI = 2'd1;           // bits 7:5
   localparam logic [1:0] dstRs = 2'd2;            // bits 10:8

   localparam logic [1:0] jmpNone = 2'd0;
   localparam logic [1:0] jmpBranch = 2'd1;        // pc+2 + imm8
   localparam logic [1:0] jmpDisp = 2'd2;          // pc+2 + imm11
   localparam logic [1:0] jmpReg = 2'd3;           // rs + imm8

   localparam logic [1:0] stIdle = 2'd0;
   localparam logic [1:0] stExec = 2'd1;
   localparam logic [1:0] stMem = 2'd2;
   localparam logic [1:0] stDone = 2'd3;

   typedef enum logic [2:0] {wbAlu, wbMem, wbLinkPc, wbImm8, wbSlbi} wbSel_e;

   typedef enum logic [2:0] {
      cndNone, cndZero, cndNotZero, cndSign, cndNotSign, cndSignOrZero, cndCarry, cndAlways
   } condSel_e;

   typedef union packed {
      struct packed {
         logic [4:0] opcode;
         logic [2:0] rs;
         logic [2:0] rt;
         logic [2:0] rd;
         logic [1:0] func;
      } rForm;
      struct packed {
         logic [4:0] opcode;
         logic [2:0] rs;
         logic [2:0] rd;
         logic [4:0] imm5;
      } iForm;
      struct packed {
         logic [4:0] opcode;
         logic [10:0] imm11;
      } jForm;
      struct packed {
         logic [4:0] opcode;
         logic [2:0] rs;
         logic [7:0] imm8;
      } biForm;
   } instrWord_u;

   typedef struct packed {
      logic [2:0] aluOp;
      logic [1:0] bSrc;
      logic zeroExt;           // zero extend imm5 / imm8
      logic invA;
      logic invB;
      logic cin;
      condSel_e condSel;
      logic setOp;             // write condition as 0/1
      logic regWrt;
      wbSel_e wbSel;
      logic [1:0] destSel;
      logic memWrt;
      logic memRd;
      logic [1:0] jumpSel;
      logic linkWrt;           // overrides destSel with r7
      logic halt;
      logic illegal;
   } ctrl_s;

   typedef struct packed {
      logic [regAddrW-1:0] dest;
      logic [dataW-1:0] data;
      logic wrEn;
   } wbReq_s;

endpackage

//--- runSim.sh
#!/bin/sh
# Build and run the wiscCore testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f wiscCore.f \
   --top-module wiscCoreTb -Mdir obj_dir -o wiscCoreSim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/wiscCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
   exit 1
fi
if [ $simStatus -ne 0 ]; then
   echo "simulator exited with status $simStatus"
   exit 1
fi
exit 0

//--- test/wiscModel.svh
`ifndef WISC_MODEL_SVH
`define WISC_MODEL_SVH

// architectural state as the host should see it
logic [15:0] mRegs [8];
logic [15:0] mMem [256];
logic [15:0] mPc;
logic mHalted;
logic mError;

// every word differs, spreads over the whole address
function automatic logic [15:0] memFill(input int i);
   return 16'(i * 257) ^ 16'h5a3c;
endfunction

function automatic void modelReset();
   for (int i = 0; i < 8; i++) mRegs[i] = '0;
   for (int i = 0; i < 256; i++) mMem[i] = memFill(i);
   mPc = '0;
   mHalted = 1'b0;
   mError = 1'b0;
endfunction

// kind: 0 rol, 1 sll, 2 ror, 3 srl
function automatic logic [15:0] shiftRes(input logic [15:0] v, input logic [3:0] n,
                                         input logic [1:0] kind);
   case (kind)
      2'd0: return (v << n) | (v >> (16 - n));
      2'd1: return v << n;
      2'd2: return (v >> n) | (v << (16 - n));
      default: return v >> n;
   endcase
endfunction

function automatic void modelExec(input logic [15:0] w);
   logic [4:0] op;
   logic [15:0] a;
   logic [15:0] b;
   logic [15:0] s5;
   logic [15:0] z5;
   logic [15:0] s8;
   logic [15:0] s11;
   logic [15:0] res;
   logic [15:0] ea;
   logic [15:0] npc;
   logic [16:0] wide;
   logic [2:0] dst;
   logic wr;
   op = w[15:11];
   a = mRegs[w[10:8]];                   // rs
   b = mRegs[w[7:5]];                    // rt, also store data
   s5 = {{11{w[4]}}, w[4:0]};
   z5 = {11'b0, w[4:0]};
   s8 = {{8{w[7]}}, w[7:0]};
   s11 = {{5{w[10]}}, w[10:0]};
   ea = a + s5;
   npc = mPc + 16'd2;
   res = '0;
   dst = w[7:5];                         // I-form rd unless changed
   wr = 1'b1;
   if (mHalted) return;                  // halted core ignores everything
   case (op)
      5'b00000: begin mHalted = 1'b1; wr = 1'b0; npc = mPc; end
      5'b00001: wr = 1'b0;
      5'b01000: res = a + s5;
      5'b01001: res = s5 - a;            // imm minus rs
      5'b01010: res = a ^ z5;
      5'b01011: res = a & ~z5;
      5'b10100, 5'b10101, 5'b10110, 5'b10111: res = shiftRes(a, w[3:0], op[1:0]);
      5'b11010: begin res = shiftRes(a, b[3:0], w[1:0]); dst = w[4:2]; end
      5'b11011: begin
         dst = w[4:2];
         case (w[1:0])
            2'd0: res = a + b;
            2'd1: res = b - a;           // rt minus rs
            2'd2: res = a ^ b;
            default: res = a & ~b;
         endcase
      end
      5'b11100: begin res = {15'b0, a == b}; dst = w[4:2]; end
      5'b11101: begin res = {15'b0, $signed(a) < $signed(b)}; dst = w[4:2]; end
      5'b11110: begin res = {15'b0, $signed(a) <= $signed(b)}; dst = w[4:2]; end
      5'b11111: begin wide = {1'b0, a} + {1'b0, b}; res = {15'b0, wide[16]}; dst = w[4:2]; end
      5'b10001: res = mMem[ea[7:0]];
      5'b10000: begin mMem[ea[7:0]] = b; wr = 1'b0; end
      5'b10011: begin mMem[ea[7:0]] = b; res = ea; dst = w[10:8]; end
      5'b11000: begin res = s8; dst = w[10:8]; end
      5'b10010: begin res = {a[7:0], w[7:0]}; dst = w[10:8]; end
      5'b01100: begin wr = 1'b0; if (a == 0) npc = npc + s8; end
      5'b01101: begin wr = 1'b0; if (a != 0) npc = npc + s8; end
      5'b01110: begin wr = 1'b0; if (a[15]) npc = npc + s8; end
      5'b01111: begin wr = 1'b0; if (!a[15]) npc = npc + s8; end
      5'b00100: begin wr = 1'b0; npc = npc + s11; end
      5'b00101: begin wr = 1'b0; npc = a + s8; end
      5'b00110: begin res = npc; dst = 3'd7; npc = npc + s11; end
      5'b00111: begin res = npc; dst = 3'd7; npc = a + s8; end
      default: begin mError = 1'b1; wr = 1'b0; npc = mPc; end
   endcase
   if (wr) mRegs[dst] = res;
   mPc = npc;
endfunction

function automatic logic [15:0] modelHostRead(input logic [3:0] adr);
   if (adr < 4'd8) return mRegs[adr[2:0]];
   if (adr == 4'd8) return mPc;
   if (adr == 4'd9) return {14'b0, mError, mHalted};
   return '0;
endfunction

`endif

//--- test/wiscCoreTb.sv
`timescale 1ns/100ps
module wiscCoreTb;

   logic clk;
   logic rstN;
   logic cyc;
   logic stb;
   logic we;
   logic [3:0] adr;
   logic [15:0] datWr;
   logic [15:0] datRd;
   logic ack;
   logic memCyc;
   logic memStb;
   logic memWe;
   logic [15:0] memAdr;
   logic [15:0] memDatWr;
   logic [15:0] memDatRd = '0;
   logic memAck = 1'b0;
   logic [15:0] memArr [256];
   logic [31:0] stimRng;
   logic [31:0] memRng = 32'hdddf4732;    // own stream for the memory delays
   logic memBusy = 1'b0;
   logic [1:0] memWait = '0;
   logic stbHeld = 1'b0;
   int cycleCnt = 0;
   int txnCnt = 0;

   `include "wiscModel.svh"

   wiscCore i_wiscCore (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic reportFailure(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic checkEq(input string name, input logic [15:0] got, input logic [15:0] exp);
      assert (got === exp)
         else reportFailure($sformatf("ERR %s got %h expected %h", name, got, exp));
   endtask

   // class 0 alu/set/lbi, 1 memory, 2 branch/jump, 3 illegal
   function automatic logic [15:0] pickInstr(input int cls);
      logic [31:0] r;
      logic [4:0] op;
      stimRng = lcgNext(stimRng);
      r = stimRng;
      case (cls)
         0: case (r[29:27])
            3'd0, 3'd1: op = {3'b010, r[31:30]};        // addi subi xori andni
            3'd2: op = {3'b101, r[31:30]};              // shift immediates
            3'd3: op = 5'b11011;
            3'd4: op = 5'b11010;
            3'd5: op = {3'b111, r[31:30]};              // seq slt sle sco
            3'd6: op = 5'b11000;
            default: op = 5'b10010;
         endcase
         1: op = (r[31:30] == 2'd0) ? 5'b10001 : (r[31:30] == 2'd1 ? 5'b10000 : 5'b10011);
         2: op = {1'b0, r[29] ? 2'b11 : 2'b01, r[31:30]};
         default: op = r[31] ? 5'b11001 : {4'b0001, r[30]};
      endcase
      return {op, r[26:16]};
   endfunction

   task automatic hostWrite(input logic [15:0] w, output int edges, output logic memAckAtAck);
      @(negedge clk);
      cyc = 1'b1;
      stb = 1'b1;
      we = 1'b1;
      adr = 4'd0;
      datWr = w;
      txnCnt++;
      edges = 0;
      do begin
         @(posedge clk);                 // ack taken before the edge updates
         edges++;
      end while (!ack);
      memAckAtAck = memAck;
      @(negedge clk);
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
   endtask

   task automatic hostRead(input logic [3:0] a, output logic [15:0] data);
      @(negedge clk);
      cyc = 1'b1;
      stb = 1'b1;
      we = 1'b0;
      adr = a;
      txnCnt++;
      do @(posedge clk); while (!ack);
      data = datRd;
      @(negedge clk);
      cyc = 1'b0;
      stb = 1'b0;
   endtask

   // r0..r7, pc and status
   task automatic checkHostView();
      logic [15:0] got;
      string name;
      for (int i = 0; i < 10; i++) begin
         hostRead(4'(i), got);
         if (i < 8) begin
            name = $sformatf("r%0d", i);
         end else if (i == 8) begin
            name = "pc";
         end else begin
            name = "status";
         end
         checkEq(name, got, modelHostRead(4'(i)));
      end
   endtask

   task automatic runInstr(input logic [15:0] w);
      int edges;
      logic sawMemAck;
      logic isMem;
      logic wasHalted;
      isMem = (w[15:11] == 5'b10001) || (w[15:11] == 5'b10000) || (w[15:11] == 5'b10011);
      wasHalted = mHalted;
      hostWrite(w, edges, sawMemAck);
      modelExec(w);
      if (isMem && !wasHalted) begin
         assert (sawMemAck) else reportFailure($sformatf("host ack before memAck on %h", w));
      end else begin
         assert (edges == 3)             // stb seen on edge 1, ack 2 cycles later
            else reportFailure($sformatf("instruction %h acked %0d cycles after stb", w, edges - 1));
      end
   endtask

   // memory slave, 0 to 3 wait cycles
   always @(negedge clk) begin
      if (memAck) begin
         memAck = 1'b0;
      end else if (memCyc && memStb) begin
         if (!memBusy) begin
            memBusy = 1'b1;
            memRng = lcgNext(memRng);
            memWait = memRng[17:16];
         end
         if (memWait == 2'd0) begin
            memAck = 1'b1;
            memBusy = 1'b0;
            if (memWe) memArr[memAdr[7:0]] = memDatWr;
            else memDatRd = memArr[memAdr[7:0]];
         end else begin
            memWait = memWait - 2'd1;
         end
      end
   end

   // bus protocol and timeout
   always @(posedge clk) begin
      if (rstN) begin
         assert (!ack || (cyc && stb))
            else reportFailure("ack raised outside a host transaction");
         assert (!stbHeld || (memCyc && memStb))
            else reportFailure("memory strobe dropped before memAck");
      end
      stbHeld <= memStb && !memAck;
      cycleCnt <= cycleCnt + 1;
      if (cycleCnt > 40 * (txnCnt + 1)) begin
         reportFailure($sformatf("timeout after %0d cycles", cycleCnt));
      end
   end

   initial begin
      rstN = 1'b0;
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      adr = '0;
      datWr = '0;
      stimRng = 32'hdddf4732;
      modelReset();
      for (int i = 0; i < 256; i++) memArr[i] = memFill(i);
      repeat (2) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;

      checkHostView();                   // all zero after reset
      runInstr(16'h0800);                // nop, 2 cycle ack
      checkHostView();

      for (int i = 0; i < 200; i++) begin
         runInstr(pickInstr(0));
         if (i % 20 == 19) checkHostView();
      end

      for (int i = 0; i < 60; i++) begin
         runInstr(pickInstr(1));
         if (i % 10 == 9) checkHostView();
      end
      for (int i = 0; i < 256; i++) checkEq($sformatf("mem[%0d]", i), memArr[i], mMem[i]);

      for (int i = 0; i < 60; i++) begin
         runInstr(pickInstr(i % 4 == 3 ? 0 : 2));   // refresh rs now and then
         checkHostView();
      end

      runInstr(pickInstr(3));
      checkHostView();                   // error set, regs unchanged
      runInstr(16'h0000);                // halt
      checkHostView();
      for (int i = 0; i < 6; i++) runInstr(pickInstr(i % 3));
      checkHostView();
      for (int i = 0; i < 256; i++) checkEq($sformatf("mem[%0d]", i), memArr[i], mMem[i]);

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- wiscCore.f
+incdir+test
hw/wiscPkg.sv
hw/instrDecode.sv
hw/regFile.sv
hw/aluExecute.sv
hw/resultStage.sv
hw/busSequencer.sv
hw/wiscCore.sv
test/wiscCoreTb.sv
